//--- rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Datapath and instruction widths
`define XLEN 64
`define ILEN 32

// Integer register file
`define NUM_REGS   32
`define REG_ADDR_W 5

// Byte step between sequential instructions
`define PC_STEP 4

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes in instr[6:0]; anything else decodes as a NOP
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011, // ADDI ANDI ORI XORI SLLI SRLI
    OP     = 7'b0110011, // ADD SUB AND OR XOR
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    BRANCH = 7'b1100011  // Only BEQ is kept
  } opcode_e;

  // funct3 values shared by OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD = 3'b000, // Also SUB and BEQ
    F3_SLL = 3'b001,
    F3_XOR = 3'b100,
    F3_SRL = 3'b101,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_e;

  // Operations the execute ALU knows
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_PASS_B = 4'd7, // LUI result is the immediate itself
    ALU_LINK   = 4'd8  // JAL return address
  } alu_op_e;

  // funct7 for SUB on OP
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_e;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_core_defines.svh"

package rv_pipe_pkg;

  // Decoded item waiting for or sitting in execute
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op_a;    // rs1 value
    logic [`XLEN-1:0]       op_b;    // rs2 value
    logic [`XLEN-1:0]       imm;     // Sign extended, format picked by decode
    rv_isa_pkg::alu_op_e    alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_we;   // Never set for x0 or unsupported encodings
    logic                   is_jal;
    logic                   is_beq;
    logic                   use_imm; // Immediate replaces op_b at the ALU
  } exec_req_t;

  // Write-back register, also the register file write port
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_t;

endpackage

//--- fetch_decode_if.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

// One fetched instruction handed from fetch to decode
interface fetch_decode_if;
  logic             valid; // Slot holds an instruction
  logic             ready; // Decode takes it on this edge
  logic [`ILEN-1:0] instr;
  logic [`XLEN-1:0] pc;    // Address the instruction came from

  modport fetch (
    output valid,
    output instr,
    output pc,
    input  ready
  );

  modport decode (
    input  valid,
    input  instr,
    input  pc,
    output ready
  );
endinterface

//--- instr_fetch.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module instr_fetch (
  input  logic             clk,
  input  logic             reset,
  input  logic [`XLEN-1:0] entry,
  output logic             imem_req_valid,
  output logic [`XLEN-1:0] imem_addr,
  input  logic             imem_req_ready,
  input  logic             imem_rsp_valid,
  input  logic [`ILEN-1:0] imem_rsp_data,
  input  logic             redirect_valid,
  input  logic [`XLEN-1:0] redirect_pc,
  fetch_decode_if.fetch    fd
);

  logic [`XLEN-1:0] pc;          // Address of the next request
  logic [`XLEN-1:0] req_pc;      // Address of the request in flight
  logic             started;     // Low through reset and the first cycle after it
  logic             outstanding; // One request accepted, no response yet
  logic             stale;       // In-flight response belongs to a flushed path
  logic             slot_valid;
  logic [`ILEN-1:0] slot_instr;
  logic [`XLEN-1:0] slot_pc;
  logic             slot_free;
  logic             req_fire;
  logic             rsp_keep;

  // Slot is empty now or drains into decode on this edge
  assign slot_free      = !slot_valid || fd.ready;
  assign imem_req_valid = started && !outstanding && slot_free;
  assign imem_addr      = pc;
  assign req_fire       = imem_req_valid && imem_req_ready;
  assign rsp_keep       = imem_rsp_valid && !stale && !redirect_valid; // Flushed otherwise

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= entry; // Entry point sampled for as long as reset holds
      started     <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
      slot_valid  <= 1'b0;
    end else begin
      started <= 1'b1;

      if (redirect_valid) begin
        pc <= redirect_pc; // Taken branch or jump wins over sequential step
      end else if (req_fire) begin
        pc <= pc + `XLEN'(`PC_STEP);
      end

      if (req_fire) begin
        outstanding <= 1'b1;
      end else if (imem_rsp_valid) begin
        outstanding <= 1'b0;
      end

      // Request still on its way when the path changes
      if (redirect_valid && (req_fire || (outstanding && !imem_rsp_valid))) begin
        stale <= 1'b1;
      end else if (imem_rsp_valid) begin
        stale <= 1'b0; // Dropped response just arrived
      end

      if (redirect_valid) begin
        slot_valid <= 1'b0;
      end else if (rsp_keep) begin
        slot_valid <= 1'b1;
      end else if (slot_valid && fd.ready) begin
        slot_valid <= 1'b0;
      end
    end
  end

  // Payload follows the control flags
  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_pc <= pc;
    end
    if (redirect_valid) begin
      slot_instr <= `NOP_INSTR; // Flushed slot holds a harmless encoding
    end else if (rsp_keep) begin
      slot_instr <= imem_rsp_data;
      slot_pc    <= req_pc;
    end
  end

  assign fd.valid = slot_valid;
  assign fd.instr = slot_instr;
  assign fd.pc    = slot_pc;

endmodule

//--- register_file.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module register_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  rv_pipe_pkg::wb_t       wb
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data; // x0 stays zero
    end
  end

  // Reads see the array as it stands, no bypass from the write port
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- instr_decode.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module instr_decode (
  input  logic                    clk,
  input  logic                    reset,
  fetch_decode_if.decode          fd,
  output logic [`REG_ADDR_W-1:0]  rs1_addr,
  output logic [`REG_ADDR_W-1:0]  rs2_addr,
  input  logic [`XLEN-1:0]        rs1_data,
  input  logic [`XLEN-1:0]        rs2_data,
  output logic                    exec_valid,
  input  logic                    exec_ready,
  output rv_pipe_pkg::exec_req_t  exec_req,
  input  logic [`REG_ADDR_W-1:0]  ex_rd,
  input  logic                    ex_rd_we,
  input  rv_pipe_pkg::wb_t        wb,
  input  logic                    redirect_valid
);

  rv_isa_pkg::opcode_e    opcode;
  rv_isa_pkg::funct3_e    funct3;
  rv_isa_pkg::funct7_e    funct7;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       imm_i, imm_u, imm_j, imm_b;
  logic                   supported;
  logic                   writes_rd;
  logic                   rs1_used, rs2_used;
  logic                   rs1_hazard, rs2_hazard;
  logic                   stall;
  logic                   take;
  rv_pipe_pkg::exec_req_t req_next;

  assign opcode   = rv_isa_pkg::opcode_e'(fd.instr[6:0]);
  assign funct3   = rv_isa_pkg::funct3_e'(fd.instr[14:12]);
  assign funct7   = rv_isa_pkg::funct7_e'(fd.instr[31:25]);
  assign rd       = fd.instr[11:7];
  assign rs1_addr = fd.instr[19:15];
  assign rs2_addr = fd.instr[24:20];

  // Immediate formats, all sign extended from instr[31]
  assign imm_i = {{(`XLEN-12){fd.instr[31]}}, fd.instr[31:20]};
  assign imm_u = {{(`XLEN-32){fd.instr[31]}}, fd.instr[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                  fd.instr[20], fd.instr[30:21], 1'b0};
  assign imm_b = {{(`XLEN-13){fd.instr[31]}}, fd.instr[31], fd.instr[7],
                  fd.instr[30:25], fd.instr[11:8], 1'b0};

  assign rs1_used = opcode inside {rv_isa_pkg::OP_IMM, rv_isa_pkg::OP, rv_isa_pkg::BRANCH};
  assign rs2_used = opcode inside {rv_isa_pkg::OP, rv_isa_pkg::BRANCH};

  // rs has a write pending from one in-flight source
  function automatic logic pending_write(input logic [`REG_ADDR_W-1:0] rs,
                                         input logic                   we,
                                         input logic [`REG_ADDR_W-1:0] dest);
    pending_write = we && (dest == rs) && (rs != '0);
  endfunction

  // Sources are our own slot, execute and write-back
  assign rs1_hazard = pending_write(rs1_addr, exec_valid && exec_req.rd_we, exec_req.rd) ||
                      pending_write(rs1_addr, ex_rd_we, ex_rd) ||
                      pending_write(rs1_addr, wb.valid, wb.rd);
  assign rs2_hazard = pending_write(rs2_addr, exec_valid && exec_req.rd_we, exec_req.rd) ||
                      pending_write(rs2_addr, ex_rd_we, ex_rd) ||
                      pending_write(rs2_addr, wb.valid, wb.rd);

  assign stall    = (rs1_used && rs1_hazard) || (rs2_used && rs2_hazard);
  assign fd.ready = (!exec_valid || exec_ready) && !stall;
  assign take     = fd.valid && fd.ready && !redirect_valid;

  always_comb begin
    req_next        = '0;
    req_next.pc     = fd.pc;
    req_next.op_a   = rs1_data;
    req_next.op_b   = rs2_data;
    req_next.rd     = rd;
    req_next.alu_op = rv_isa_pkg::ALU_ADD;
    supported       = 1'b0;
    writes_rd       = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        req_next.imm     = imm_i;
        req_next.use_imm = 1'b1;
        writes_rd        = 1'b1;
        supported        = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_ADD: req_next.alu_op = rv_isa_pkg::ALU_ADD;
          rv_isa_pkg::F3_AND: req_next.alu_op = rv_isa_pkg::ALU_AND;
          rv_isa_pkg::F3_OR:  req_next.alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_XOR: req_next.alu_op = rv_isa_pkg::ALU_XOR;
          rv_isa_pkg::F3_SLL: begin
            req_next.alu_op = rv_isa_pkg::ALU_SLL;
            supported       = (fd.instr[31:26] == '0); // 6-bit shamt on RV64
          end
          rv_isa_pkg::F3_SRL: begin
            req_next.alu_op = rv_isa_pkg::ALU_SRL;
            supported       = (fd.instr[31:26] == '0); // SRAI not kept
          end
          default: supported = 1'b0; // SLTI, SLTIU
        endcase
      end
      rv_isa_pkg::OP: begin
        writes_rd = 1'b1;
        supported = (funct7 == rv_isa_pkg::F7_BASE);
        case (funct3)
          rv_isa_pkg::F3_ADD: begin
            if (funct7 == rv_isa_pkg::F7_ALT) begin
              req_next.alu_op = rv_isa_pkg::ALU_SUB;
              supported       = 1'b1;
            end else begin
              req_next.alu_op = rv_isa_pkg::ALU_ADD;
            end
          end
          rv_isa_pkg::F3_AND: req_next.alu_op = rv_isa_pkg::ALU_AND;
          rv_isa_pkg::F3_OR:  req_next.alu_op = rv_isa_pkg::ALU_OR;
          rv_isa_pkg::F3_XOR: req_next.alu_op = rv_isa_pkg::ALU_XOR;
          default: supported = 1'b0; // Register shifts and compares dropped
        endcase
      end
      rv_isa_pkg::LUI: begin
        req_next.imm     = imm_u;
        req_next.use_imm = 1'b1;
        req_next.alu_op  = rv_isa_pkg::ALU_PASS_B;
        writes_rd        = 1'b1;
        supported        = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        req_next.imm    = imm_j;
        req_next.alu_op = rv_isa_pkg::ALU_LINK;
        req_next.is_jal = 1'b1;
        writes_rd       = 1'b1;
        supported       = 1'b1;
      end
      rv_isa_pkg::BRANCH: begin
        req_next.imm    = imm_b;
        supported       = (fd.instr[14:12] == 3'b000); // BEQ only
        req_next.is_beq = supported;
      end
      default: supported = 1'b0;
    endcase
    req_next.rd_we = supported && writes_rd && (rd != '0);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exec_valid <= 1'b0;
    end else if (redirect_valid) begin
      exec_valid <= 1'b0; // Younger than the taken branch
    end else if (take) begin
      exec_valid <= 1'b1;
    end else if (exec_ready) begin
      exec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      exec_req <= req_next;
    end
  end

endmodule

//--- alu_execute.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module alu_execute (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   exec_valid,
  output logic                   exec_ready,
  input  rv_pipe_pkg::exec_req_t exec_req,
  output logic [`REG_ADDR_W-1:0] ex_rd,
  output logic                   ex_rd_we,
  output logic                   redirect_valid,
  output logic [`XLEN-1:0]       redirect_pc,
  output rv_pipe_pkg::wb_t       wb
);

  logic                   ex_valid;
  rv_pipe_pkg::exec_req_t ex_req;
  logic [`XLEN-1:0]       op_b;
  logic [`XLEN-1:0]       result;
  logic                   wb_valid_q;
  logic [`REG_ADDR_W-1:0] wb_rd_q;
  logic [`XLEN-1:0]       wb_data_q;

  // Slot drains every cycle; only a flush turns the next item away
  assign exec_ready = !redirect_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= exec_valid && exec_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid && exec_ready) begin
      ex_req <= exec_req;
    end
  end

  assign op_b = ex_req.use_imm ? ex_req.imm : ex_req.op_b;

  always_comb begin
    case (ex_req.alu_op)
      rv_isa_pkg::ALU_ADD:    result = ex_req.op_a + op_b;
      rv_isa_pkg::ALU_SUB:    result = ex_req.op_a - op_b;
      rv_isa_pkg::ALU_AND:    result = ex_req.op_a & op_b;
      rv_isa_pkg::ALU_OR:     result = ex_req.op_a | op_b;
      rv_isa_pkg::ALU_XOR:    result = ex_req.op_a ^ op_b;
      rv_isa_pkg::ALU_SLL:    result = ex_req.op_a << op_b[5:0];
      rv_isa_pkg::ALU_SRL:    result = ex_req.op_a >> op_b[5:0];
      rv_isa_pkg::ALU_PASS_B: result = op_b;
      rv_isa_pkg::ALU_LINK:   result = ex_req.pc + `XLEN'(`PC_STEP);
      default:                result = '0;
    endcase
  end

  // BEQ compares the register operands, never the immediate
  assign redirect_valid = ex_valid &&
                          (ex_req.is_jal || (ex_req.is_beq && ex_req.op_a == ex_req.op_b));
  assign redirect_pc    = ex_req.pc + ex_req.imm;

  assign ex_rd    = ex_req.rd;
  assign ex_rd_we = ex_valid && ex_req.rd_we; // Seen by the decode hazard check

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ex_valid && ex_req.rd_we; // NOPs and branches write nothing
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= ex_req.rd;
    wb_data_q <= result;
  end

  assign wb.valid = wb_valid_q;
  assign wb.rd    = wb_rd_q;
  assign wb.data  = wb_data_q;

endmodule

//--- rv_core.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module rv_core (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       entry,
  output logic                   imem_req_valid,
  output logic [`XLEN-1:0]       imem_addr,
  input  logic                   imem_req_ready,
  input  logic                   imem_rsp_valid,
  input  logic [`ILEN-1:0]       imem_rsp_data,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic                   exec_valid;
  logic                   exec_ready;
  rv_pipe_pkg::exec_req_t exec_req;
  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [`XLEN-1:0]       rs1_data, rs2_data;
  logic [`REG_ADDR_W-1:0] ex_rd;
  logic                   ex_rd_we;
  logic                   redirect_valid;
  logic [`XLEN-1:0]       redirect_pc;
  rv_pipe_pkg::wb_t       wb;

  fetch_decode_if fd_if ();

  instr_fetch instr_fetch_inst (
    .clk            (clk),
    .reset          (reset),
    .entry          (entry),
    .imem_req_valid (imem_req_valid),
    .imem_addr      (imem_addr),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rsp_data  (imem_rsp_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fd             (fd_if.fetch)
  );

  instr_decode instr_decode_inst (
    .clk            (clk),
    .reset          (reset),
    .fd             (fd_if.decode),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .exec_valid     (exec_valid),
    .exec_ready     (exec_ready),
    .exec_req       (exec_req),
    .ex_rd          (ex_rd),
    .ex_rd_we       (ex_rd_we),
    .wb             (wb),
    .redirect_valid (redirect_valid)
  );

  alu_execute alu_execute_inst (
    .clk            (clk),
    .reset          (reset),
    .exec_valid     (exec_valid),
    .exec_ready     (exec_ready),
    .exec_req       (exec_req),
    .ex_rd          (ex_rd),
    .ex_rd_we       (ex_rd_we),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .wb             (wb)
  );

  register_file register_file_inst (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  // Write-back register straight out to the top
  assign wb_valid = wb.valid;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;

endmodule

//--- tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_core_defines.svh"

module tb_rv_core;

  localparam logic [63:0] ENTRY_PC = 64'h1000;
  localparam int PROG_ROWS      = 28;
  localparam int EXP_ROWS       = 19;
  localparam int TIMEOUT_CYCLES = PROG_ROWS * 40 + 100;
  localparam int QUIET_CYCLES   = 40; // Self-loop must stay silent this long

  logic        clk;
  logic        reset;
  logic [63:0] entry;
  logic        imem_req_valid;
  logic [63:0] imem_addr;
  logic        imem_req_ready;
  logic        imem_rsp_valid;
  logic [31:0] imem_rsp_data;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data;

  logic [31:0] prog_mem [PROG_ROWS];
  logic [68:0] wb_table [EXP_ROWS]; // {rd, data}

  logic [31:0] rng_state;
  logic        req_taken;      // Handshake seen before the coming edge
  logic [63:0] taken_addr;
  logic        rsp_pending;
  logic [1:0]  rsp_delay;
  logic [31:0] rsp_word;
  logic        first_req_seen;
  int          cycle_count;
  int          matched;

  rv_core rv_core_inst (
    .clk            (clk),
    .reset          (reset),
    .entry          (entry),
    .imem_req_valid (imem_req_valid),
    .imem_addr      (imem_addr),
    .imem_req_ready (imem_req_ready),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rsp_data  (imem_rsp_data),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data)
  );

  always #10 clk = !clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // OP_IMM encodings
  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111}; // LUI
  endfunction

  function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // BEQ only
  function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] instr_at(input logic [63:0] addr);
    logic [63:0] index;
    index = (addr - ENTRY_PC) >> 2;
    if (addr < ENTRY_PC || index >= PROG_ROWS) begin
      return `NOP_INSTR; // Outside the program
    end
    return prog_mem[index];
  endfunction

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic fill_tables();
    prog_mem[0]  = i_format(12'h005, 5'd0, 3'b000, 5'd1);          // ADDI x1, x0, 5
    prog_mem[1]  = i_format(12'hFFD, 5'd1, 3'b000, 5'd2);          // ADDI x2, x1, -3
    prog_mem[2]  = i_format(12'h006, 5'd1, 3'b111, 5'd3);          // ANDI x3, x1, 6
    prog_mem[3]  = i_format(12'h070, 5'd2, 3'b110, 5'd4);          // ORI x4, x2, 0x70
    prog_mem[4]  = i_format(12'hFFF, 5'd4, 3'b100, 5'd5);          // XORI x5, x4, -1
    prog_mem[5]  = i_format(12'h028, 5'd1, 3'b001, 5'd6);          // SLLI x6, x1, 40
    prog_mem[6]  = i_format(12'h03C, 5'd5, 3'b101, 5'd7);          // SRLI x7, x5, 60
    prog_mem[7]  = r_format(7'h00, 5'd7, 5'd6, 3'b000, 5'd8);      // ADD x8, x6, x7
    prog_mem[8]  = r_format(7'h20, 5'd1, 5'd2, 3'b000, 5'd9);      // SUB x9, x2, x1
    prog_mem[9]  = r_format(7'h00, 5'd4, 5'd9, 3'b111, 5'd10);     // AND x10, x9, x4
    prog_mem[10] = r_format(7'h00, 5'd3, 5'd10, 3'b110, 5'd11);    // OR x11, x10, x3
    prog_mem[11] = r_format(7'h00, 5'd9, 5'd11, 3'b100, 5'd12);    // XOR x12, x11, x9
    prog_mem[12] = u_format(20'h12345, 5'd13);                     // LUI x13
    prog_mem[13] = u_format(20'h80000, 5'd14);                     // LUI x14, sign bit set
    prog_mem[14] = i_format(12'h007, 5'd1, 3'b000, 5'd0);          // ADDI x0, x1, 7
    prog_mem[15] = r_format(7'h00, 5'd1, 5'd0, 3'b000, 5'd15);     // ADD x15, x0, x1
    prog_mem[16] = b_format(13'd8, 5'd2, 5'd1);                    // BEQ x1, x2 not taken
    prog_mem[17] = i_format(12'h001, 5'd0, 3'b000, 5'd16);         // ADDI x16, x0, 1
    prog_mem[18] = b_format(13'd12, 5'd3, 5'd3);                   // BEQ x3, x3 to row 21
    prog_mem[19] = i_format(12'h055, 5'd0, 3'b000, 5'd17);         // Skipped
    prog_mem[20] = i_format(12'h066, 5'd0, 3'b000, 5'd18);         // Skipped
    prog_mem[21] = j_format(21'd12, 5'd19);                        // JAL x19 to row 24
    prog_mem[22] = i_format(12'h077, 5'd0, 3'b000, 5'd20);         // Skipped
    prog_mem[23] = i_format(12'h088, 5'd0, 3'b000, 5'd21);         // Skipped
    prog_mem[24] = r_format(7'h00, 5'd16, 5'd19, 3'b000, 5'd22);   // ADD x22, x19, x16
    prog_mem[25] = i_format(12'h001, 5'd0, 3'b010, 5'd23);         // SLTI, not kept
    prog_mem[26] = i_format(12'h000, 5'd22, 3'b000, 5'd24);        // ADDI x24, x22, 0
    prog_mem[27] = j_format(21'd0, 5'd0);                          // JAL x0 self-loop

    wb_table[0]  = {5'd1,  64'h0000_0000_0000_0005};
    wb_table[1]  = {5'd2,  64'h0000_0000_0000_0002};
    wb_table[2]  = {5'd3,  64'h0000_0000_0000_0004};
    wb_table[3]  = {5'd4,  64'h0000_0000_0000_0072};
    wb_table[4]  = {5'd5,  64'hFFFF_FFFF_FFFF_FF8D};
    wb_table[5]  = {5'd6,  64'h0000_0500_0000_0000};
    wb_table[6]  = {5'd7,  64'h0000_0000_0000_000F};
    wb_table[7]  = {5'd8,  64'h0000_0500_0000_000F};
    wb_table[8]  = {5'd9,  64'hFFFF_FFFF_FFFF_FFFD};
    wb_table[9]  = {5'd10, 64'h0000_0000_0000_0070};
    wb_table[10] = {5'd11, 64'h0000_0000_0000_0074};
    wb_table[11] = {5'd12, 64'hFFFF_FFFF_FFFF_FF89};
    wb_table[12] = {5'd13, 64'h0000_0000_1234_5000};
    wb_table[13] = {5'd14, 64'hFFFF_FFFF_8000_0000};
    wb_table[14] = {5'd15, 64'h0000_0000_0000_0005}; // x0 read as zero
    wb_table[15] = {5'd16, 64'h0000_0000_0000_0001}; // Fall-through after BEQ
    wb_table[16] = {5'd19, 64'h0000_0000_0000_1058}; // JAL link, pc 0x1054 plus 4
    wb_table[17] = {5'd22, 64'h0000_0000_0000_1059};
    wb_table[18] = {5'd24, 64'h0000_0000_0000_1059};
  endtask

  // Handshake state taken mid-cycle, where it is settled
  always @(negedge clk) begin
    req_taken  = imem_req_valid && imem_req_ready && !reset;
    taken_addr = imem_addr;
  end

  // Instruction memory with random ready and 0 to 3 cycles of response delay
  always @(posedge clk) begin
    if (reset) begin
      imem_req_ready <= 1'b0;
      imem_rsp_valid <= 1'b0;
      rsp_pending = 1'b0;
    end else begin
      rng_state = xorshift32(rng_state);
      imem_req_ready <= (rng_state[1:0] != 2'b00);
      imem_rsp_valid <= 1'b0;
      if (req_taken) begin
        assert (!rsp_pending) else begin
          $display("A new instruction request was accepted before the last was answered");
          stop_with_failure();
        end
        if (!first_req_seen) begin
          assert (taken_addr === ENTRY_PC) else begin
            $display("[ERROR] imem_addr: expected 0x%0h got 0x%0h", ENTRY_PC, taken_addr);
            stop_with_failure();
          end
          first_req_seen = 1'b1;
        end
        rng_state   = xorshift32(rng_state);
        rsp_delay   = rng_state[1:0];
        rsp_word    = instr_at(taken_addr);
        rsp_pending = 1'b1;
      end
      if (rsp_pending) begin
        if (rsp_delay == 2'd0) begin
          imem_rsp_valid <= 1'b1;
          imem_rsp_data  <= rsp_word;
          rsp_pending = 1'b0;
        end else begin
          rsp_delay = rsp_delay - 2'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d write-backs seen",
               cycle_count, matched, EXP_ROWS);
      stop_with_failure();
    end
  end

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    entry          = ENTRY_PC;
    imem_req_ready = 1'b0;
    imem_rsp_valid = 1'b0;
    imem_rsp_data  = `NOP_INSTR;
    rng_state      = 32'h61da4df3;
    rsp_pending    = 1'b0;
    rsp_delay      = 2'd0;
    rsp_word       = `NOP_INSTR;
    first_req_seen = 1'b0;
    cycle_count    = 0;
    matched        = 0;
    fill_tables();

    repeat (7) begin
      @(negedge clk);
      assert (wb_valid === 1'b0) else begin
        $display("[ERROR] wb_valid: expected 0x0 got 0x%0h during reset", wb_valid);
        stop_with_failure();
      end
      assert (imem_req_valid === 1'b0) else begin
        $display("[ERROR] imem_req_valid: expected 0x0 got 0x%0h during reset",
                 imem_req_valid);
        stop_with_failure();
      end
    end
    @(posedge clk);
    reset <= 1'b0; // Eighth edge in reset

    for (int row = 0; row < EXP_ROWS; row++) begin
      do begin
        @(negedge clk);
      end while (wb_valid !== 1'b1);
      assert (wb_rd === wb_table[row][68:64]) else begin
        $display("[ERROR] wb_rd: expected 0x%0h got 0x%0h at row %0d",
                 wb_table[row][68:64], wb_rd, row);
        stop_with_failure();
      end
      assert (wb_data === wb_table[row][63:0]) else begin
        $display("[ERROR] wb_data: expected 0x%0h got 0x%0h at row %0d",
                 wb_table[row][63:0], wb_data, row);
        stop_with_failure();
      end
      matched++;
    end

    // Nothing more may retire once the self-loop is reached
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (wb_valid === 1'b0) else begin
        $display("[ERROR] wb_valid: expected 0x0 got 0x%0h after the last write-back, rd 0x%0h",
                 wb_valid, wb_rd);
        stop_with_failure();
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- rv_core.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
fetch_decode_if.sv
instr_fetch.sv
register_file.sv
instr_decode.sv
alu_execute.sv
rv_core.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - rv_isa_pkg.sv
  - rv_pipe_pkg.sv
  - fetch_decode_if.sv
  - instr_fetch.sv
  - register_file.sv
  - instr_decode.sv
  - alu_execute.sv
  - rv_core.sv
  - target: test
    files:
      - tb_rv_core.sv
